// ==== design/rx_dcore_pkg.sv ====
package rx_dcore_pkg;

    ////////////////////////////////////////
    // widths and counts
    ////////////////////////////////////////

    // interleaved slices
    localparam int NTI = 4;
    // adc code width
    localparam int NADC = 8;
    // phase interpolator outputs
    localparam int NOUT = 4;
    // pi control width
    localparam int NPI = 9;
    // prbs order
    localparam int NPRBS = 7;

    // generator start value, must be nonzero
    localparam logic [NPRBS-1:0] PRBS_SEED = 7'd1;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    typedef logic [NADC-1:0] adc_code_t;
    typedef logic signed [NADC-1:0] signed_code_t;
    typedef logic [NTI-1:0] lane_mask_t;
    typedef logic [NPI-1:0] pi_ctl_t;
    typedef logic [3:0] max_sel_t;
    typedef logic [31:0] count_t;

    // saturation limits of the unfolded code
    localparam signed_code_t CODE_MAX = signed_code_t'(2 ** (NADC - 1) - 1);
    localparam signed_code_t CODE_MIN = signed_code_t'(-(2 ** (NADC - 1)));

    // checker fills its history first, then compares
    typedef enum logic {
        CHK_SEED,
        CHK_RUN
    } chk_state_t;

endpackage

// ==== design/prbs_check_if.sv ====
`timescale 1ns/1ps

interface prbs_check_if import rx_dcore_pkg::*; #(
    parameter int lanes = NTI
) ();

    // bits under test, one per slice
    logic [lanes-1:0] rx_bits;
    logic             cke;
    // lanes taking part in the count
    logic [lanes-1:0] chan_sel;
    count_t           err_count;
    count_t           total_count;
    logic             locked;

    modport src (output rx_bits);

    modport chk (
        input  rx_bits, cke, chan_sel,
        output err_count, total_count, locked
    );

    modport top (
        output cke, chan_sel,
        input  rx_bits, err_count, total_count, locked
    );

endinterface

// ==== design/adc_unfold.sv ====
`timescale 1ns/1ps

module adc_unfold import rx_dcore_pkg::*; #(
    parameter int lanes = NTI
) (
    input  wire logic         clk_adc,
    input  wire logic         rstb,
    input  wire adc_code_t    adcout_i [lanes-1:0],
    input  wire logic [lanes-1:0] adcout_sign_i,
    input  wire signed_code_t pfd_offset_i [lanes-1:0],
    output signed_code_t      adc_unfolded_o [lanes-1:0]
);

    // two extra bits cover +/-255 less the offset
    typedef logic signed [NADC+1:0] wide_code_t;

    localparam wide_code_t SAT_HI = wide_code_t'(CODE_MAX);
    localparam wide_code_t SAT_LO = wide_code_t'(CODE_MIN);

    for (genvar i = 0; i < lanes; i++) begin : g_lane
        wide_code_t   mag;
        wide_code_t   diff;
        signed_code_t sat_code;

        // magnitude is always positive
        assign mag  = wide_code_t'({2'b00, adcout_i[i]});

        // sign bit set means positive side
        assign diff = (adcout_sign_i[i] ? mag : -mag) - wide_code_t'(pfd_offset_i[i]);

        assign sat_code = (diff > SAT_HI) ? CODE_MAX :
                          (diff < SAT_LO) ? CODE_MIN :
                          signed_code_t'(diff);

        always_ff @(posedge clk_adc or negedge rstb) begin
            if (!rstb) begin
                adc_unfolded_o[i] <= '0;
            end else begin
                adc_unfolded_o[i] <= sat_code;
            end
        end
    end

endmodule

// ==== design/rx_decision.sv ====
`timescale 1ns/1ps

module rx_decision import rx_dcore_pkg::*; #(
    parameter int lanes = NTI
) (
    input  wire logic         clk_adc,
    input  wire logic         rstb,
    input  wire signed_code_t codes_i [lanes-1:0],
    input  wire signed_code_t thresh_i,
    input  wire logic         sel_bist_i,
    input  wire logic         bist_bit_i,
    prbs_check_if.src         chk_o
);

    logic [lanes-1:0] sliced;
    logic [lanes-1:0] chosen;

    ////////////////////////////////////////
    // slicer
    ////////////////////////////////////////

    // signed compare, strictly above threshold gives a one
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            sliced[i] = (codes_i[i] > thresh_i);
        end
    end

    // bist bit goes to every lane
    assign chosen = sel_bist_i ? {lanes{bist_bit_i}} : sliced;

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge rstb) begin
        if (!rstb) begin
            chk_o.rx_bits <= '0;
        end else begin
            chk_o.rx_bits <= chosen;
        end
    end

endmodule

// ==== design/prbs_gen.sv ====
`timescale 1ns/1ps

module prbs_gen import rx_dcore_pkg::*; (
    input  wire logic clk_adc,
    input  wire logic rstb,
    input  wire logic cke_i,
    input  wire logic inj_err_i,
    output logic      bit_o
);

    logic [NPRBS-1:0] lfsr;
    logic             feedback;

    // x^7 + x^6 + 1
    assign feedback = lfsr[NPRBS-1] ^ lfsr[NPRBS-2];

    ////////////////////////////////////////
    // shift register
    ////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge rstb) begin
        if (!rstb) begin
            lfsr <= PRBS_SEED;
        end else if (cke_i) begin
            lfsr <= {lfsr[NPRBS-2:0], feedback};
        end
    end

    // inverted for one cycle per injected error
    assign bit_o = lfsr[NPRBS-1] ^ inj_err_i;

endmodule

// ==== design/prbs_checker.sv ====
`timescale 1ns/1ps

module prbs_checker import rx_dcore_pkg::*; #(
    parameter int lanes = NTI
) (
    input  wire logic clk_adc,
    input  wire logic rstb,
    prbs_check_if.chk chk_i
);

    localparam int SEED_W = $clog2(NPRBS + 1);

    chk_state_t        state;
    logic [SEED_W-1:0] seed_cnt;
    logic [NPRBS-1:0]  hist [lanes-1:0];
    logic [lanes-1:0]  predicted;
    logic [lanes-1:0]  mismatch;

    ////////////////////////////////////////
    // prediction from the history taps
    ////////////////////////////////////////

    // taps 7 and 6 of the received stream
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            predicted[i] = hist[i][NPRBS-1] ^ hist[i][NPRBS-2];
        end
    end

    // only selected lanes count as errors
    assign mismatch = (predicted ^ chk_i.rx_bits) & chk_i.chan_sel;

    assign chk_i.locked = (state == CHK_RUN);

    ////////////////////////////////////////
    // history, state and counters
    ////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge rstb) begin
        if (!rstb) begin
            state             <= CHK_SEED;
            seed_cnt          <= '0;
            chk_i.err_count   <= '0;
            chk_i.total_count <= '0;
            for (int i = 0; i < lanes; i++) begin
                hist[i] <= '0;
            end
        end else if (chk_i.cke) begin
            // history always follows the received bits, so the checker resyncs itself
            for (int i = 0; i < lanes; i++) begin
                hist[i] <= {hist[i][NPRBS-2:0], chk_i.rx_bits[i]};
            end

            case (state)
                CHK_SEED: begin
                    seed_cnt <= seed_cnt + 1'b1;
                    // history is full after NPRBS bits
                    if (seed_cnt == SEED_W'(NPRBS - 1)) begin
                        state <= CHK_RUN;
                    end
                end
                CHK_RUN: begin
                    chk_i.err_count   <= chk_i.err_count + count_t'($countones(mismatch));
                    chk_i.total_count <= chk_i.total_count
                                         + count_t'($countones(chk_i.chan_sel));
                end
                default: begin
                    state <= CHK_SEED;
                end
            endcase
        end
    end

endmodule

// ==== design/pi_ctl_scaler.sv ====
`timescale 1ns/1ps

module pi_ctl_scaler import rx_dcore_pkg::*; #(
    parameter int n_out = NOUT,
    parameter int n_pi  = NPI
) (
    input  wire logic            clk_adc,
    input  wire logic            rstb,
    input  wire logic [n_pi-1:0] pi_ctl_i [n_out-1:0],
    input  wire logic [n_pi-1:0] pi_ctl_offset_i [n_out-1:0],
    input  wire max_sel_t        max_sel_mux_i [n_out-1:0],
    input  wire logic [n_out-1:0] en_bypass_i,
    input  wire logic [n_pi-1:0] bypass_pi_ctl_i [n_out-1:0],
    output logic [n_pi-1:0]      pi_ctl_o [n_out-1:0]
);

    for (genvar j = 0; j < n_out; j++) begin : g_out
        logic [n_pi-1:0]   shifted;
        logic [n_pi-1:0]   scale;
        logic [2*n_pi-1:0] product;
        logic [n_pi-1:0]   scaled;

        // wraps modulo 2**n_pi
        assign shifted = pi_ctl_i[j] + pi_ctl_offset_i[j];

        // (max_sel + 1) * 16 - 1
        assign scale = ((n_pi'(max_sel_mux_i[j]) + n_pi'(1)) << 4) - n_pi'(1);

        assign product = (2 * n_pi)'(shifted) * (2 * n_pi)'(scale);

        // upper half, i.e. product >> n_pi
        assign scaled = product[2*n_pi-1:n_pi];

        always_ff @(posedge clk_adc or negedge rstb) begin
            if (!rstb) begin
                pi_ctl_o[j] <= '0;
            end else if (en_bypass_i[j]) begin
                pi_ctl_o[j] <= bypass_pi_ctl_i[j];
            end else begin
                pi_ctl_o[j] <= scaled;
            end
        end
    end

endmodule

// ==== design/rx_dcore_top.sv ====
`timescale 1ns/1ps

module rx_dcore_top import rx_dcore_pkg::*; (
    input  wire logic         clk_adc,
    input  wire logic         rstb,

    // adc slices
    input  wire adc_code_t    adcout_i [NTI-1:0],
    input  wire lane_mask_t   adcout_sign_i,
    input  wire signed_code_t pfd_offset_i [NTI-1:0],
    input  wire signed_code_t adc_thresh_i,

    // prbs bist
    input  wire logic         sel_bist_i,
    input  wire logic         prbs_gen_cke_i,
    input  wire logic         prbs_inj_err_i,
    input  wire logic         prbs_chk_cke_i,
    input  wire lane_mask_t   prbs_chan_sel_i,

    // pi control
    input  wire pi_ctl_t      pi_ctl_i [NOUT-1:0],
    input  wire pi_ctl_t      pi_ctl_offset_i [NOUT-1:0],
    input  wire max_sel_t     max_sel_mux_i [NOUT-1:0],
    input  wire logic [NOUT-1:0] en_bypass_pi_ctl_i,
    input  wire pi_ctl_t      bypass_pi_ctl_i [NOUT-1:0],

    output signed_code_t      adc_unfolded_o [NTI-1:0],
    output lane_mask_t        rx_bits_o,
    output count_t            prbs_err_count_o,
    output count_t            prbs_total_count_o,
    output logic              prbs_locked_o,
    output pi_ctl_t           int_pi_ctl_o [NOUT-1:0]
);

    logic bist_bit;

    prbs_check_if #(.lanes(NTI)) chk_bus ();

    assign chk_bus.cke         = prbs_chk_cke_i;
    assign chk_bus.chan_sel    = prbs_chan_sel_i;
    assign rx_bits_o           = chk_bus.rx_bits;
    assign prbs_err_count_o    = chk_bus.err_count;
    assign prbs_total_count_o  = chk_bus.total_count;
    assign prbs_locked_o       = chk_bus.locked;

    ////////////////////////////////////////
    // adc path
    ////////////////////////////////////////

    adc_unfold #(.lanes(NTI)) adc_unfold_inst (
        .clk_adc        (clk_adc),
        .rstb           (rstb),
        .adcout_i       (adcout_i),
        .adcout_sign_i  (adcout_sign_i),
        .pfd_offset_i   (pfd_offset_i),
        .adc_unfolded_o (adc_unfolded_o)
    );

    rx_decision #(.lanes(NTI)) rx_decision_inst (
        .clk_adc    (clk_adc),
        .rstb       (rstb),
        .codes_i    (adc_unfolded_o),
        .thresh_i   (adc_thresh_i),
        .sel_bist_i (sel_bist_i),
        .bist_bit_i (bist_bit),
        .chk_o      (chk_bus.src)
    );

    ////////////////////////////////////////
    // bist
    ////////////////////////////////////////

    prbs_gen prbs_gen_inst (
        .clk_adc   (clk_adc),
        .rstb      (rstb),
        .cke_i     (prbs_gen_cke_i),
        .inj_err_i (prbs_inj_err_i),
        .bit_o     (bist_bit)
    );

    prbs_checker #(.lanes(NTI)) prbs_checker_inst (
        .clk_adc (clk_adc),
        .rstb    (rstb),
        .chk_i   (chk_bus.chk)
    );

    // pi codes to the analog core
    pi_ctl_scaler #(
        .n_out (NOUT),
        .n_pi  (NPI)
    ) pi_ctl_scaler_inst (
        .clk_adc         (clk_adc),
        .rstb            (rstb),
        .pi_ctl_i        (pi_ctl_i),
        .pi_ctl_offset_i (pi_ctl_offset_i),
        .max_sel_mux_i   (max_sel_mux_i),
        .en_bypass_i     (en_bypass_pi_ctl_i),
        .bypass_pi_ctl_i (bypass_pi_ctl_i),
        .pi_ctl_o        (int_pi_ctl_o)
    );

endmodule

// ==== testbench/rx_dcore_asserts.sv ====
`timescale 1ns/1ps

module rx_dcore_asserts import rx_dcore_pkg::*; (
    input wire logic   clk_adc,
    input wire logic   rstb,
    input chk_state_t  state,
    input wire logic   cke,
    input wire count_t err_count,
    input wire count_t total_count,
    input wire logic   locked
);

    ////////////////////////////////////////
    // checker properties
    ////////////////////////////////////////

    // errors only accumulate
    err_no_decrease: assert property (
        @(posedge clk_adc) disable iff (!rstb)
        err_count >= $past(err_count)
    ) else $error("prbs err_count went down");

    // once running, the checker stays locked until reset
    lock_sticky: assert property (
        @(posedge clk_adc) disable iff (!rstb)
        (state == CHK_RUN) |=> locked
    ) else $error("checker lost lock without a reset");

    // a frozen checker keeps its total
    total_hold: assert property (
        @(posedge clk_adc) disable iff (!rstb)
        !cke |=> $stable(total_count)
    ) else $error("total_count changed while cke was low");

endmodule

// ==== testbench/tb_rx_dcore.sv ====
`timescale 1ns/1ps

module tb_rx_dcore import rx_dcore_pkg::*; ();

    localparam int N_HAND      = 8;
    localparam int N_UNFOLD    = 32;
    localparam int N_PI        = 32;
    localparam lane_mask_t CHAN_SEL = 4'b1011;
    localparam int LANES_ON    = $countones(CHAN_SEL);
    localparam int WINDOW      = 20;
    localparam int N_PULSE     = 4;
    localparam int PULSE_GAP   = 12;
    localparam int HOLD        = 12;
    localparam int BIST_CYCLES = 2 + 2 * NPRBS + WINDOW + N_PULSE * PULSE_GAP + HOLD;
    localparam int LIMIT       = 2 * (N_UNFOLD + N_PI) + BIST_CYCLES + 100;

    typedef struct {
        adc_code_t    mag;
        logic         sign;
        signed_code_t offset;
        signed_code_t thresh;
        signed_code_t code;
        logic         dec;
    } unfold_row_t;

    typedef struct {
        pi_ctl_t  code;
        pi_ctl_t  offset;
        max_sel_t sel;
        logic     byp;
        pi_ctl_t  byp_code;
        pi_ctl_t  result;
    } pi_row_t;

    logic            clk_adc;
    logic            rstb;
    adc_code_t       adcout [NTI-1:0];
    lane_mask_t      adcout_sign;
    signed_code_t    pfd_offset [NTI-1:0];
    signed_code_t    adc_thresh;
    logic            sel_bist;
    logic            gen_cke;
    logic            inj_err;
    logic            chk_cke;
    lane_mask_t      chan_sel;
    pi_ctl_t         pi_ctl [NOUT-1:0];
    pi_ctl_t         pi_offset [NOUT-1:0];
    max_sel_t        max_sel [NOUT-1:0];
    logic [NOUT-1:0] en_bypass;
    pi_ctl_t         bypass_code [NOUT-1:0];

    signed_code_t    adc_unfolded [NTI-1:0];
    lane_mask_t      rx_bits;
    count_t          err_count;
    count_t          total_count;
    logic            locked;
    pi_ctl_t         int_pi_ctl [NOUT-1:0];

    unfold_row_t     unfold_tab [N_UNFOLD];
    pi_row_t         pi_tab [N_PI];
    int              cycles = 0;
    count_t          last_err;
    count_t          last_total;
    // reference prbs7 register, x^7 + x^6 + 1
    logic [NPRBS-1:0] prbs_ref;

    rx_dcore_top rx_dcore_top_inst (
        .clk_adc            (clk_adc),
        .rstb               (rstb),
        .adcout_i           (adcout),
        .adcout_sign_i      (adcout_sign),
        .pfd_offset_i       (pfd_offset),
        .adc_thresh_i       (adc_thresh),
        .sel_bist_i         (sel_bist),
        .prbs_gen_cke_i     (gen_cke),
        .prbs_inj_err_i     (inj_err),
        .prbs_chk_cke_i     (chk_cke),
        .prbs_chan_sel_i    (chan_sel),
        .pi_ctl_i           (pi_ctl),
        .pi_ctl_offset_i    (pi_offset),
        .max_sel_mux_i      (max_sel),
        .en_bypass_pi_ctl_i (en_bypass),
        .bypass_pi_ctl_i    (bypass_code),
        .adc_unfolded_o     (adc_unfolded),
        .rx_bits_o          (rx_bits),
        .prbs_err_count_o   (err_count),
        .prbs_total_count_o (total_count),
        .prbs_locked_o      (locked),
        .int_pi_ctl_o       (int_pi_ctl)
    );

    bind prbs_checker rx_dcore_asserts checker_asserts_inst (
        .clk_adc     (clk_adc),
        .rstb        (rstb),
        .state       (state),
        .cke         (chk_i.cke),
        .err_count   (chk_i.err_count),
        .total_count (chk_i.total_count),
        .locked      (chk_i.locked)
    );

    initial clk_adc = 1'b0;
    always #5 clk_adc = ~clk_adc;

    always @(posedge clk_adc) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            abort_run();
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    // drive and sample 1 ns after the edge
    task automatic tick();
        @(posedge clk_adc);
        #1;
    endtask

    // one bist cycle, rx_bits must carry the reference bit on every lane
    task automatic bist_tick(input logic flip);
        logic exp_bit;
        exp_bit = prbs_ref[NPRBS-1] ^ flip;
        tick();
        compare("rx_bits_o", 32'(rx_bits), 32'({NTI{exp_bit}}));
        prbs_ref = {prbs_ref[NPRBS-2:0], prbs_ref[NPRBS-1] ^ prbs_ref[NPRBS-2]};
    endtask

    // signed unfolding, offset removal, saturation to 8 bits
    function automatic signed_code_t unfold_rule(input adc_code_t mag, input logic sign,
                                                 input signed_code_t offset);
        int val;
        val = sign ? int'(mag) : -int'(mag);
        val = val - int'(offset);
        if (val > 127) begin
            val = 127;
        end else if (val < -128) begin
            val = -128;
        end
        return signed_code_t'(val);
    endfunction

    function automatic pi_ctl_t pi_rule(input pi_ctl_t code, input pi_ctl_t offset,
                                        input max_sel_t sel);
        int sum;
        int scale;
        sum   = (int'(code) + int'(offset)) % 512;
        scale = (int'(sel) + 1) * 16 - 1;
        return pi_ctl_t'((sum * scale) >> NPI);
    endfunction

    task automatic build_tables();
        // magnitude, sign, offset, threshold, code, bit
        unfold_tab[0] = '{8'd0, 1'b1, 8'h00, 8'h00, 8'h00, 1'b0};
        unfold_tab[1] = '{8'd100, 1'b1, 8'h0a, 8'h32, 8'h5a, 1'b1};
        unfold_tab[2] = '{8'd100, 1'b0, 8'h0a, 8'h80, 8'h92, 1'b1};
        unfold_tab[3] = '{8'd255, 1'b1, 8'h00, 8'h00, 8'h7f, 1'b1};
        unfold_tab[4] = '{8'd255, 1'b0, 8'h00, 8'h00, 8'h80, 1'b0};
        unfold_tab[5] = '{8'd120, 1'b1, 8'hec, 8'h7f, 8'h7f, 1'b0};
        unfold_tab[6] = '{8'd0, 1'b0, 8'h7f, 8'h81, 8'h81, 1'b0};
        unfold_tab[7] = '{8'd1, 1'b0, 8'h80, 8'h7e, 8'h7f, 1'b1};
        // code, offset, max_sel, bypass enable, bypass code, result
        pi_tab[0] = '{9'd0, 9'd0, 4'd0, 1'b0, 9'h000, 9'h000};
        pi_tab[1] = '{9'd511, 9'd0, 4'd15, 1'b0, 9'h000, 9'h0fe};
        pi_tab[2] = '{9'd256, 9'd0, 4'd15, 1'b0, 9'h000, 9'h07f};
        pi_tab[3] = '{9'd500, 9'd20, 4'd7, 1'b0, 9'h000, 9'h001};
        pi_tab[4] = '{9'd300, 9'd0, 4'd0, 1'b0, 9'h000, 9'h008};
        pi_tab[5] = '{9'd123, 9'd0, 4'd15, 1'b1, 9'h1a5, 9'h1a5};
        pi_tab[6] = '{9'd100, 9'd412, 4'd15, 1'b0, 9'h000, 9'h000};
        pi_tab[7] = '{9'd400, 9'd50, 4'd3, 1'b0, 9'h000, 9'h037};
        for (int k = N_HAND; k < N_UNFOLD; k++) begin
            unfold_tab[k].mag    = adc_code_t'($urandom_range(0, 160));
            unfold_tab[k].sign   = 1'($urandom);
            unfold_tab[k].offset = signed_code_t'(int'($urandom_range(0, 60)) - 30);
            unfold_tab[k].thresh = signed_code_t'($urandom);
            unfold_tab[k].code   = unfold_rule(unfold_tab[k].mag, unfold_tab[k].sign,
                                               unfold_tab[k].offset);
            unfold_tab[k].dec    = unfold_tab[k].code > unfold_tab[k].thresh;
        end
        for (int k = N_HAND; k < N_PI; k++) begin
            pi_tab[k].code     = pi_ctl_t'($urandom);
            pi_tab[k].offset   = pi_ctl_t'($urandom);
            pi_tab[k].sel      = max_sel_t'($urandom);
            pi_tab[k].byp      = ($urandom_range(0, 3) == 0);
            pi_tab[k].byp_code = pi_ctl_t'($urandom);
            pi_tab[k].result   = pi_tab[k].byp ? pi_tab[k].byp_code :
                                 pi_rule(pi_tab[k].code, pi_tab[k].offset, pi_tab[k].sel);
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int r;
        void'($urandom(32'h4771));
        rstb        = 1'b0;
        adcout_sign = '0;
        adc_thresh  = '0;
        sel_bist    = 1'b0;
        gen_cke     = 1'b0;
        inj_err     = 1'b0;
        chk_cke     = 1'b0;
        chan_sel    = '0;
        en_bypass   = '0;
        for (int j = 0; j < NTI; j++) begin
            adcout[j]     = '0;
            pfd_offset[j] = '0;
        end
        for (int j = 0; j < NOUT; j++) begin
            pi_ctl[j]      = '0;
            pi_offset[j]   = '0;
            max_sel[j]     = '0;
            bypass_code[j] = '0;
        end
        build_tables();

        repeat (2) @(posedge clk_adc);
        #1;
        rstb = 1'b1;
        for (int j = 0; j < NTI; j++) begin
            compare($sformatf("adc_unfolded_o[%0d]", j), 32'(adc_unfolded[j]), '0);
        end
        for (int j = 0; j < NOUT; j++) begin
            compare($sformatf("int_pi_ctl_o[%0d]", j), 32'(int_pi_ctl[j]), '0);
        end
        compare("rx_bits_o", 32'(rx_bits), '0);
        compare("prbs_err_count_o", err_count, '0);
        compare("prbs_total_count_o", total_count, '0);
        compare("prbs_locked_o", 32'(locked), '0);

        // threshold trails its adc row by one cycle, in step with the unfolded code
        for (int k = 0; k < N_UNFOLD + 2; k++) begin
            if (k < N_UNFOLD) begin
                adcout_sign = {NTI{unfold_tab[k].sign}};
                for (int j = 0; j < NTI; j++) begin
                    adcout[j]     = unfold_tab[k].mag;
                    pfd_offset[j] = unfold_tab[k].offset;
                end
            end
            if (k >= 1 && k <= N_UNFOLD) begin
                adc_thresh = unfold_tab[k-1].thresh;
            end
            tick();
            for (int j = 0; j < NTI && k < N_UNFOLD; j++) begin
                compare($sformatf("adc_unfolded_o[%0d]", j), 32'(adc_unfolded[j]),
                        32'(unfold_tab[k].code));
            end
            if (k >= 1 && k <= N_UNFOLD) begin
                compare("rx_bits_o", 32'(rx_bits), 32'({NTI{unfold_tab[k-1].dec}}));
            end
        end

        // each output walks the table from its own start row
        for (int k = 0; k < N_PI; k++) begin
            for (int j = 0; j < NOUT; j++) begin
                r              = (k + j) % N_PI;
                pi_ctl[j]      = pi_tab[r].code;
                pi_offset[j]   = pi_tab[r].offset;
                max_sel[j]     = pi_tab[r].sel;
                en_bypass[j]   = pi_tab[r].byp;
                bypass_code[j] = pi_tab[r].byp_code;
            end
            tick();
            for (int j = 0; j < NOUT; j++) begin
                compare($sformatf("int_pi_ctl_o[%0d]", j), 32'(int_pi_ctl[j]),
                        32'(pi_tab[(k + j) % N_PI].result));
            end
        end

        // generator first, checker joins once rx_bits carries the prbs
        sel_bist = 1'b1;
        gen_cke  = 1'b1;
        chan_sel = CHAN_SEL;
        prbs_ref = PRBS_SEED;
        repeat (2) bist_tick(1'b0);
        chk_cke = 1'b1;
        while (!locked) begin
            bist_tick(1'b0);
        end
        last_total = total_count;
        for (int c = 0; c < WINDOW; c++) begin
            bist_tick(1'b0);
            compare("prbs_err_count_o", err_count, '0);
            compare("prbs_total_count_o", total_count, last_total + count_t'(LANES_ON));
            last_total = total_count;
        end

        // one flipped bit hits the compare, then taps 6 and 7
        for (int p = 0; p < N_PULSE; p++) begin
            last_err = err_count;
            inj_err  = 1'b1;
            bist_tick(1'b1);
            inj_err = 1'b0;
            repeat (PULSE_GAP - 1) bist_tick(1'b0);
            compare("prbs_err_count_o", err_count, last_err + count_t'(3 * LANES_ON));
        end

        last_err   = err_count;
        last_total = total_count;
        chk_cke    = 1'b0;
        repeat (HOLD) begin
            bist_tick(1'b0);
            compare("prbs_err_count_o", err_count, last_err);
            compare("prbs_total_count_o", total_count, last_total);
            compare("prbs_locked_o", 32'(locked), 32'd1);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== rx_dcore.f ====
design/rx_dcore_pkg.sv
design/prbs_check_if.sv
design/adc_unfold.sv
design/rx_decision.sv
design/prbs_gen.sv
design/prbs_checker.sv
design/pi_ctl_scaler.sv
design/rx_dcore_top.sv
testbench/rx_dcore_asserts.sv
testbench/tb_rx_dcore.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_rx_dcore
FILELIST ?= rx_dcore.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
PASS_MSG := NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
